/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = axi_iso_tb
FILELIST = axi_iso_top.f
LOG      = sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* axi_iso_top.f */
src/axi_iso_pkg.sv
src/axi_iso_txn_counter.sv
src/axi_iso_ctrl.sv
src/axi_iso_write_path.sv
src/axi_iso_read_path.sv
src/axi_iso_top.sv
verif/axi_iso_clkgen.sv
verif/axi_iso_tb.sv

/* src/axi_iso_ctrl.sv */
`timescale 1ns/100ps

module axi_iso_ctrl (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      isolate_i,
  input  axi_iso_pkg::chan_status_t wr_status_i,
  input  axi_iso_pkg::chan_status_t rd_status_i,
  output axi_iso_pkg::iso_state_e   wr_state_o,
  output axi_iso_pkg::iso_state_e   rd_state_o,
  output logic                      isolated_o
);
  import axi_iso_pkg::*;

  iso_state_e wr_state_q;
  iso_state_e wr_state_d;
  iso_state_e rd_state_q;
  iso_state_e rd_state_d;

  //////////////////////////////////////////////////////////////////////
  // Shared transition function for both directions
  //////////////////////////////////////////////////////////////////////

  function automatic iso_state_e next_state(
    input iso_state_e   state,
    input logic         isolate,
    input chan_status_t status
  );
    iso_state_e nxt;
    nxt = state;
    unique case (state)
      ISO_NORMAL: begin
        // A presented but unaccepted address must be held first
        if (status.stall) begin
          nxt = ISO_HOLD;
        end else if (isolate) begin
          nxt = ISO_DRAIN;
        end
      end
      ISO_HOLD: begin
        // Leave once the held address is taken downstream
        if (status.accept) begin
          nxt = isolate ? ISO_DRAIN : ISO_NORMAL;
        end
      end
      ISO_DRAIN: begin
        // Wait for every open transaction to complete
        if (status.empty) begin
          nxt = ISO_ISOLATE;
        end
      end
      ISO_ISOLATE: begin
        if (!isolate) begin
          nxt = ISO_NORMAL;
        end
      end
    endcase
    return nxt;
  endfunction

  assign wr_state_d = next_state(wr_state_q, isolate_i, wr_status_i);
  assign rd_state_d = next_state(rd_state_q, isolate_i, rd_status_i);

  // Come out of reset isolated, release needs isolate_i low
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_state_q <= ISO_ISOLATE;
      rd_state_q <= ISO_ISOLATE;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
    end
  end

  assign wr_state_o = wr_state_q;
  assign rd_state_o = rd_state_q;

  // Isolated only once both directions have drained
  assign isolated_o = (wr_state_q == ISO_ISOLATE) && (rd_state_q == ISO_ISOLATE);

  // Both path counters must be empty when isolation is reported
  isolated_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(isolated_o) |-> (wr_status_i.empty && rd_status_i.empty));

endmodule

/* src/axi_iso_pkg.sv */
package axi_iso_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths and pending limit
  //////////////////////////////////////////////////////////////////////

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Open transactions allowed per counter
  localparam int NUM_PENDING = 4;
  // Counter must hold 0 up to NUM_PENDING inclusive
  localparam int CNT_W = $clog2(NUM_PENDING + 1);

  //////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////

  // Write address, no user or atop fields
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } aw_chan_t;

  // Read address, same layout as AW
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ar_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

  //////////////////////////////////////////////////////////////////////
  // Bundles and control types
  //////////////////////////////////////////////////////////////////////

  // Manager to subordinate direction
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager direction
  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // One machine per direction, write and read
  typedef enum logic [1:0] {
    ISO_NORMAL,
    ISO_HOLD,
    ISO_DRAIN,
    ISO_ISOLATE
  } iso_state_e;

  // Address side status reported by each path
  typedef struct packed {
    logic stall;
    logic accept;
    logic empty;
  } chan_status_t;

endpackage

/* src/axi_iso_read_path.sv */
`timescale 1ns/100ps

module axi_iso_read_path (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  axi_iso_pkg::iso_state_e   rd_state_i,
  input  axi_iso_pkg::axi_req_t     slv_req_i,
  input  axi_iso_pkg::axi_resp_t    mst_resp_i,
  output axi_iso_pkg::chan_status_t rd_status_o,
  output axi_iso_pkg::ar_chan_t     mst_ar_o,
  output logic                      mst_ar_valid_o,
  output logic                      mst_r_ready_o,
  output logic                      slv_ar_ready_o,
  output axi_iso_pkg::r_chan_t      slv_r_o,
  output logic                      slv_r_valid_o
);
  import axi_iso_pkg::*;

  logic ar_full;
  logic ar_empty;
  logic ar_count;
  logic r_last_done;

  //////////////////////////////////////////////////////////////////////
  // AR and R gating by read state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mst_ar_o       = slv_req_i.ar;
    mst_ar_valid_o = slv_req_i.ar_valid;
    slv_ar_ready_o = mst_resp_i.ar_ready;
    slv_r_o        = mst_resp_i.r;
    slv_r_valid_o  = mst_resp_i.r_valid;
    mst_r_ready_o  = slv_req_i.r_ready;
    unique case (rd_state_i)
      ISO_NORMAL: begin
        // Limit reached, hold new reads back
        if (ar_full) begin
          mst_ar_valid_o = 1'b0;
          slv_ar_ready_o = 1'b0;
        end
      end
      ISO_HOLD: begin
        mst_ar_valid_o = 1'b1;
      end
      ISO_DRAIN: begin
        // R still flows so open reads can finish
        mst_ar_o       = '0;
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
      end
      ISO_ISOLATE: begin
        mst_ar_o       = '0;
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
        slv_r_o        = '0;
        slv_r_valid_o  = 1'b0;
        mst_r_ready_o  = 1'b0;
      end
    endcase
  end

  // Counted on entry from NORMAL, HOLD only completes it
  assign ar_count    = mst_ar_valid_o && (rd_state_i == ISO_NORMAL);
  // a read closes on its final beat
  assign r_last_done = mst_resp_i.r_valid && mst_r_ready_o && mst_resp_i.r.last;

  axi_iso_txn_counter u_ar_cnt (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (ar_count),
    .dec_i   (r_last_done),
    .count_o (),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

  assign rd_status_o.stall  = mst_ar_valid_o && !mst_resp_i.ar_ready;
  assign rd_status_o.accept = mst_ar_valid_o && mst_resp_i.ar_ready;
  assign rd_status_o.empty  = ar_empty;

endmodule

/* src/axi_iso_top.sv */
`timescale 1ns/100ps

module axi_iso_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  axi_iso_pkg::axi_req_t  slv_req_i,
  output axi_iso_pkg::axi_resp_t slv_resp_o,
  output axi_iso_pkg::axi_req_t  mst_req_o,
  input  axi_iso_pkg::axi_resp_t mst_resp_i,
  input  logic                   isolate_i,
  output logic                   isolated_o
);
  import axi_iso_pkg::*;

  iso_state_e   wr_state;
  iso_state_e   rd_state;
  chan_status_t wr_status;
  chan_status_t rd_status;

  // Path outputs before merging into the bundles
  aw_chan_t mst_aw;
  logic     mst_aw_valid;
  w_chan_t  mst_w;
  logic     mst_w_valid;
  logic     mst_b_ready;
  logic     slv_aw_ready;
  logic     slv_w_ready;
  b_chan_t  slv_b;
  logic     slv_b_valid;
  ar_chan_t mst_ar;
  logic     mst_ar_valid;
  logic     mst_r_ready;
  logic     slv_ar_ready;
  r_chan_t  slv_r;
  logic     slv_r_valid;

  //////////////////////////////////////////////////////////////////////
  // Control and channel paths
  //////////////////////////////////////////////////////////////////////

  axi_iso_ctrl u_ctrl (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .isolate_i   (isolate_i),
    .wr_status_i (wr_status),
    .rd_status_i (rd_status),
    .wr_state_o  (wr_state),
    .rd_state_o  (rd_state),
    .isolated_o  (isolated_o)
  );

  axi_iso_write_path u_write_path (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wr_state_i     (wr_state),
    .slv_req_i      (slv_req_i),
    .mst_resp_i     (mst_resp_i),
    .wr_status_o    (wr_status),
    .mst_aw_o       (mst_aw),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_w_o        (mst_w),
    .mst_w_valid_o  (mst_w_valid),
    .mst_b_ready_o  (mst_b_ready),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid)
  );

  axi_iso_read_path u_read_path (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .rd_state_i     (rd_state),
    .slv_req_i      (slv_req_i),
    .mst_resp_i     (mst_resp_i),
    .rd_status_o    (rd_status),
    .mst_ar_o       (mst_ar),
    .mst_ar_valid_o (mst_ar_valid),
    .mst_r_ready_o  (mst_r_ready),
    .slv_ar_ready_o (slv_ar_ready),
    .slv_r_o        (slv_r),
    .slv_r_valid_o  (slv_r_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // Bundle merge
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mst_req_o.aw       = mst_aw;
    mst_req_o.aw_valid = mst_aw_valid;
    mst_req_o.w        = mst_w;
    mst_req_o.w_valid  = mst_w_valid;
    mst_req_o.b_ready  = mst_b_ready;
    mst_req_o.ar       = mst_ar;
    mst_req_o.ar_valid = mst_ar_valid;
    mst_req_o.r_ready  = mst_r_ready;
  end

  always_comb begin
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.ar_ready = slv_ar_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

endmodule

/* src/axi_iso_txn_counter.sv */
`timescale 1ns/100ps

module axi_iso_txn_counter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        inc_i,
  input  logic                        dec_i,
  output logic [axi_iso_pkg::CNT_W-1:0] count_o,
  output logic                        full_o,
  output logic                        empty_o
);
  import axi_iso_pkg::*;

  logic [CNT_W-1:0] count_q;

  // Simultaneous open and close leaves the count as is
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + CNT_W'(1);
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - CNT_W'(1);
    end
  end

  assign count_o = count_q;
  // Full stops new addresses in the owning path
  assign full_o  = (count_q >= CNT_W'(NUM_PENDING));
  assign empty_o = (count_q == '0);

  // Completion seen with nothing open means the subordinate broke protocol
  no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (dec_i && !inc_i) |-> !empty_o);

  // Path gating must hold the address back once the limit is reached
  no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    (inc_i && !dec_i) |-> !full_o);

  // Count stays within the limit across cycles
  count_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    full_o |=> (count_q <= CNT_W'(NUM_PENDING)));

endmodule

/* src/axi_iso_write_path.sv */
`timescale 1ns/100ps

module axi_iso_write_path (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  axi_iso_pkg::iso_state_e   wr_state_i,
  input  axi_iso_pkg::axi_req_t     slv_req_i,
  input  axi_iso_pkg::axi_resp_t    mst_resp_i,
  output axi_iso_pkg::chan_status_t wr_status_o,
  output axi_iso_pkg::aw_chan_t     mst_aw_o,
  output logic                      mst_aw_valid_o,
  output axi_iso_pkg::w_chan_t      mst_w_o,
  output logic                      mst_w_valid_o,
  output logic                      mst_b_ready_o,
  output logic                      slv_aw_ready_o,
  output logic                      slv_w_ready_o,
  output axi_iso_pkg::b_chan_t      slv_b_o,
  output logic                      slv_b_valid_o
);
  import axi_iso_pkg::*;

  logic             aw_full;
  logic             aw_empty;
  logic             w_full;
  logic             w_empty;
  logic [CNT_W-1:0] w_cnt;
  logic             aw_count;
  logic             w_open;
  logic             w_last_done;
  logic             b_done;

  //////////////////////////////////////////////////////////////////////
  // AW and B gating by write state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Straight pass-through by default
    mst_aw_o       = slv_req_i.aw;
    mst_aw_valid_o = slv_req_i.aw_valid;
    slv_aw_ready_o = mst_resp_i.aw_ready;
    slv_b_o        = mst_resp_i.b;
    slv_b_valid_o  = mst_resp_i.b_valid;
    mst_b_ready_o  = slv_req_i.b_ready;
    unique case (wr_state_i)
      ISO_NORMAL: begin
        // Either counter at the limit blocks the handshake both ways
        if (aw_full || w_full) begin
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b0;
        end
      end
      ISO_HOLD: begin
        // Keep valid up until the subordinate takes the address
        mst_aw_valid_o = 1'b1;
      end
      ISO_DRAIN: begin
        mst_aw_o       = '0;
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
      end
      ISO_ISOLATE: begin
        mst_aw_o       = '0;
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
        slv_b_o        = '0;
        slv_b_valid_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
      end
    endcase
  end

  // Address counted when presented in NORMAL, a stalled one finishes in HOLD
  assign aw_count = mst_aw_valid_o && (wr_state_i == ISO_NORMAL);

  //////////////////////////////////////////////////////////////////////
  // W gating
  //////////////////////////////////////////////////////////////////////

  // W may only run ahead of an address that is open or opening now
  assign w_open = !w_empty || aw_count;

  always_comb begin
    mst_w_o       = slv_req_i.w;
    mst_w_valid_o = slv_req_i.w_valid;
    slv_w_ready_o = mst_resp_i.w_ready;
    if (!w_open) begin
      mst_w_o       = '0;
      mst_w_valid_o = 1'b0;
      slv_w_ready_o = 1'b0;
    end
  end

  assign w_last_done = mst_w_valid_o && mst_resp_i.w_ready && mst_w_o.last;
  assign b_done      = mst_resp_i.b_valid && mst_b_ready_o;
  assign w_empty     = (w_cnt == '0);

  // Open until B returns
  axi_iso_txn_counter u_aw_cnt (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (aw_count),
    .dec_i   (b_done),
    .count_o (),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  // Open until the last W beat is sent
  axi_iso_txn_counter u_w_cnt (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (aw_count),
    .dec_i   (w_last_done),
    .count_o (w_cnt),
    .full_o  (w_full),
    .empty_o ()
  );

  // Status as seen on the downstream AW side
  assign wr_status_o.stall  = mst_aw_valid_o && !mst_resp_i.aw_ready;
  assign wr_status_o.accept = mst_aw_valid_o && mst_resp_i.aw_ready;
  assign wr_status_o.empty  = aw_empty;

endmodule

/* verif/axi_iso_clkgen.sv */
`timescale 1ns/100ps

module axi_iso_clkgen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o
);

  // Free running clock, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

  // Reset held high for a fixed number of rising edges
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

/* verif/axi_iso_tb.sv */
`timescale 1ns/100ps

module axi_iso_tb;
  import axi_iso_pkg::*;

  localparam int NUM_TXN     = 55;
  localparam int WATCHDOG_NS = NUM_TXN * 64 * 8;

  logic      clk_i;
  logic      reset_i;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;
  axi_req_t  mst_req;
  axi_resp_t mst_resp;
  logic      isolate_i;
  logic      isolated_o;

  integer seed = 32'h18d9_5212;
  logic   hold_resp;

  // Manager side stimulus queues
  aw_chan_t aw_q[$];
  w_chan_t  w_q[$];
  ar_chan_t ar_q[$];
  int       wr_issued;
  int       rd_issued;

  // Expected traffic filled on upstream handshakes
  aw_chan_t        exp_aw_q[$];
  ar_chan_t        exp_ar_q[$];
  logic [ID_W-1:0] wr_id_q[$];
  ar_chan_t        rd_q[$];
  // W beats in issue order
  w_chan_t         exp_w_q[$];
  int              r_beat;
  int              open_aw;
  int              open_ar;
  int              iso_aw_hs;
  int              iso_ar_hs;
  int              wr_done;
  int              rd_done;

  // Subordinate model state
  logic [ID_W-1:0] b_ids[$];
  ar_chan_t        m_r_q[$];
  int              w_lasts;
  int              b_wait;
  int              r_wait;
  int              m_beat;
  logic            b_hs;
  logic            r_hs;

  axi_iso_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(5)) u_clkgen (
    .clk_o   (clk_i),
    .reset_o (reset_i)
  );

  axi_iso_top uut (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .isolate_i  (isolate_i),
    .isolated_o (isolated_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Read data is the address plus the beat index
  function automatic logic [DATA_W-1:0] exp_rdata(input logic [ADDR_W-1:0] addr, input int beat);
    return addr + DATA_W'(beat);
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_aw(input aw_chan_t act, input aw_chan_t exp);
    if (act !== exp) abort_run($sformatf("ERROR mst aw act=%h exp=%h", act, exp));
  endtask

  task automatic check_w(input w_chan_t act, input w_chan_t exp);
    if (act !== exp) abort_run($sformatf("ERROR mst w act=%h exp=%h", act, exp));
  endtask

  task automatic check_ar(input ar_chan_t act, input ar_chan_t exp);
    if (act !== exp) abort_run($sformatf("ERROR mst ar act=%h exp=%h", act, exp));
  endtask

  task automatic check_r(input r_chan_t act, input r_chan_t exp);
    if (act !== exp) abort_run($sformatf("ERROR slv r act=%h exp=%h", act, exp));
  endtask

  task automatic check_b(input b_chan_t act, input b_chan_t exp);
    if (act !== exp) abort_run($sformatf("ERROR slv b act=%h exp=%h", act, exp));
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) abort_run($sformatf("ERROR %s act=%h exp=%h", name, act, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Upstream manager
  //////////////////////////////////////////////////////////////////////

  task automatic issue_write;
    aw_chan_t aw;
    w_chan_t  w;
    aw.id    = ID_W'($unsigned($random(seed)));
    aw.addr  = {$unsigned($random(seed))} & 32'hffff_fffc;
    aw.len   = 8'($unsigned($random(seed)) & 3);
    aw.size  = 3'd2;
    aw.burst = 2'b01;
    aw_q.push_back(aw);
    for (int i = 0; i <= aw.len; i++) begin
      w.data = $random(seed);
      w.strb = '1;
      w.last = (i == aw.len);
      w_q.push_back(w);
      exp_w_q.push_back(w);
    end
    wr_issued++;
  endtask

  task automatic issue_read;
    ar_chan_t ar;
    ar.id    = ID_W'($unsigned($random(seed)));
    ar.addr  = {$unsigned($random(seed))} & 32'hffff_fffc;
    ar.len   = 8'($unsigned($random(seed)) & 3);
    ar.size  = 3'd2;
    ar.burst = 2'b01;
    ar_q.push_back(ar);
    rd_issued++;
  endtask

  // Each channel presents its queue head until the handshake
  initial begin
    forever begin
      @(posedge clk_i);
      if (slv_req.aw_valid && slv_resp.aw_ready) void'(aw_q.pop_front());
      if (slv_req.w_valid && slv_resp.w_ready) void'(w_q.pop_front());
      if (slv_req.ar_valid && slv_resp.ar_ready) void'(ar_q.pop_front());
      #1;
      slv_req.aw_valid = (aw_q.size() > 0);
      if (aw_q.size() > 0) slv_req.aw = aw_q[0];
      slv_req.w_valid = (w_q.size() > 0);
      if (w_q.size() > 0) slv_req.w = w_q[0];
      slv_req.ar_valid = (ar_q.size() > 0);
      if (ar_q.size() > 0) slv_req.ar = ar_q[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Downstream subordinate model
  //////////////////////////////////////////////////////////////////////

  initial begin
    forever begin
      @(posedge clk_i);
      b_hs = mst_resp.b_valid && mst_req.b_ready;
      r_hs = mst_resp.r_valid && mst_req.r_ready;
      if (!reset_i) begin
        if (mst_req.aw_valid && mst_resp.aw_ready) b_ids.push_back(mst_req.aw.id);
        if (mst_req.w_valid && mst_resp.w_ready && mst_req.w.last) w_lasts++;
        if (mst_req.ar_valid && mst_resp.ar_ready) m_r_q.push_back(mst_req.ar);
        if (b_hs) begin
          void'(b_ids.pop_front());
          w_lasts--;
          b_wait = $unsigned($random(seed)) & 3;
        end
        if (r_hs) begin
          // Next beat or next burst after a random gap
          r_wait = $unsigned($random(seed)) & 3;
          if (m_beat == m_r_q[0].len) begin
            void'(m_r_q.pop_front());
            m_beat = 0;
          end else begin
            m_beat++;
          end
        end
      end
      #1;
      mst_resp.aw_ready = ($unsigned($random(seed)) & 3) != 0;
      mst_resp.w_ready  = ($unsigned($random(seed)) & 3) != 0;
      mst_resp.ar_ready = ($unsigned($random(seed)) & 3) != 0;
      // Raised valid stays until taken
      if (!(mst_resp.b_valid && !b_hs)) begin
        mst_resp.b_valid = 1'b0;
        if (!hold_resp && b_ids.size() > 0 && w_lasts > 0) begin
          if (b_wait > 0) begin
            b_wait--;
          end else begin
            mst_resp.b_valid = 1'b1;
            mst_resp.b.id    = b_ids[0];
            mst_resp.b.resp  = 2'b00;
          end
        end
      end
      if (!(mst_resp.r_valid && !r_hs)) begin
        mst_resp.r_valid = 1'b0;
        if (!hold_resp && m_r_q.size() > 0) begin
          if (r_wait > 0) begin
            r_wait--;
          end else begin
            mst_resp.r_valid = 1'b1;
            mst_resp.r.id    = m_r_q[0].id;
            mst_resp.r.data  = exp_rdata(m_r_q[0].addr, m_beat);
            mst_resp.r.resp  = 2'b00;
            mst_resp.r.last  = (m_beat == m_r_q[0].len);
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  initial begin
    forever begin
      @(posedge clk_i);
      if (!reset_i) begin
        // Isolation is only reported with nothing open
        if (isolated_o && (open_aw != 0 || open_ar != 0)) begin
          abort_run("isolated_o is high while transactions are still open");
        end
        if (slv_req.aw_valid && slv_resp.aw_ready) begin
          exp_aw_q.push_back(slv_req.aw);
          wr_id_q.push_back(slv_req.aw.id);
        end
        if (slv_req.ar_valid && slv_resp.ar_ready) begin
          exp_ar_q.push_back(slv_req.ar);
          rd_q.push_back(slv_req.ar);
        end
        if (mst_req.aw_valid && mst_resp.aw_ready) begin
          if (exp_aw_q.size() == 0) abort_run("AW seen downstream that was never issued");
          check_aw(mst_req.aw, exp_aw_q.pop_front());
          open_aw++;
          if (isolate_i) iso_aw_hs++;
        end
        if (mst_req.w_valid && mst_resp.w_ready) begin
          if (exp_w_q.size() == 0) abort_run("W beat seen downstream that was never issued");
          check_w(mst_req.w, exp_w_q.pop_front());
        end
        if (mst_req.ar_valid && mst_resp.ar_ready) begin
          if (exp_ar_q.size() == 0) abort_run("AR seen downstream that was never issued");
          check_ar(mst_req.ar, exp_ar_q.pop_front());
          open_ar++;
          if (isolate_i) iso_ar_hs++;
        end
        if (mst_resp.b_valid && mst_req.b_ready) open_aw--;
        if (mst_resp.r_valid && mst_req.r_ready && mst_resp.r.last) open_ar--;
        if (slv_resp.b_valid && slv_req.b_ready) begin
          check_b(slv_resp.b, {wr_id_q.pop_front(), 2'b00});
          wr_done++;
        end
        if (slv_resp.r_valid && slv_req.r_ready) begin
          check_r(slv_resp.r, {rd_q[0].id, exp_rdata(rd_q[0].addr, r_beat), 2'b00,
                               1'(r_beat == rd_q[0].len)});
          if (r_beat == rd_q[0].len) begin
            void'(rd_q.pop_front());
            r_beat = 0;
            rd_done++;
          end else begin
            r_beat++;
          end
        end
        if (open_aw > NUM_PENDING) abort_run("Open writes downstream exceed the limit");
        if (open_ar > NUM_PENDING) abort_run("Open reads downstream exceed the limit");
        // At most the held address completes after isolate_i rises
        if (iso_aw_hs > 1) abort_run("New AW handshake downstream while isolating");
        if (iso_ar_hs > 1) abort_run("New AR handshake downstream while isolating");
        if (!isolate_i) begin
          iso_aw_hs = 0;
          iso_ar_hs = 0;
        end
      end
    end
  end

  // Watchdog sized from the transaction count
  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the tests completed");
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    slv_req   = '0;
    slv_req.b_ready = 1'b1;
    slv_req.r_ready = 1'b1;
    mst_resp  = '0;
    isolate_i = 1'b1;
    hold_resp = 1'b0;
    {open_aw, open_ar, iso_aw_hs, iso_ar_hs, wr_done, rd_done} = '0;
    {r_beat, w_lasts, b_wait, r_wait, m_beat} = '0;
    {wr_issued, rd_issued} = '0;
    @(negedge reset_i);

    // Traffic waits upstream while the ports are isolated
    issue_write();
    issue_read();

    // Isolated out of reset with every downstream valid and ready low
    repeat (4) begin
      @(posedge clk_i);
      check_flag("isolated_o", isolated_o, 1'b1);
      check_flag("mst aw_valid", mst_req.aw_valid, 1'b0);
      check_flag("mst w_valid", mst_req.w_valid, 1'b0);
      check_flag("mst b_ready", mst_req.b_ready, 1'b0);
      check_flag("mst ar_valid", mst_req.ar_valid, 1'b0);
      check_flag("mst r_ready", mst_req.r_ready, 1'b0);
    end
    #1 isolate_i = 1'b0;
    @(posedge clk_i);
    @(posedge clk_i);
    check_flag("isolated_o", isolated_o, 1'b0);

    // Queued traffic goes through once released
    while (wr_done < wr_issued || rd_done < rd_issued) @(posedge clk_i);

    // W offered ahead of its address is held back
    issue_write();
    aw_q.delete();
    repeat (6) begin
      @(posedge clk_i);
      check_flag("slv w_ready", slv_resp.w_ready, 1'b0);
      check_flag("mst w_valid", mst_req.w_valid, 1'b0);
    end
    #1 aw_q.push_back('{id: 4'h3, addr: 32'h100, len: 8'(w_q.size() - 1),
                        size: 3'd2, burst: 2'b01});
    while (wr_done < wr_issued) @(posedge clk_i);

    // Responses withheld so the limit is reached
    hold_resp = 1'b1;
    repeat (6) begin
      issue_write();
      issue_read();
    end
    while (open_aw < NUM_PENDING || open_ar < NUM_PENDING) @(posedge clk_i);
    repeat (10) @(posedge clk_i);

    // Drain with open transactions
    #1 isolate_i = 1'b1;
    repeat (10) @(posedge clk_i);
    check_flag("isolated_o", isolated_o, 1'b0);
    #1 hold_resp = 1'b0;
    while (!isolated_o) @(posedge clk_i);
    repeat (20) begin
      @(posedge clk_i);
      check_flag("isolated_o", isolated_o, 1'b1);
    end
    #1 isolate_i = 1'b0;
    @(posedge clk_i);
    @(posedge clk_i);
    check_flag("isolated_o", isolated_o, 1'b0);

    // Release traffic with one isolation cycle in the middle
    repeat (20) begin
      issue_write();
      issue_read();
    end
    repeat (30) @(posedge clk_i);
    #1 isolate_i = 1'b1;
    while (!isolated_o) @(posedge clk_i);
    #1 isolate_i = 1'b0;
    while (wr_done < wr_issued || rd_done < rd_issued) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    if (open_aw != 0 || open_ar != 0) begin
      abort_run("Transactions still open downstream after all responses returned");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule
